/* verilog.f */
verilog/mic_pkg.sv
verilog/i2s_rx.sv
verilog/frame_buffer.sv
verilog/xcorr_engine.sv
verilog/lag_peak.sv
verilog/mic_subsys.sv
dv/tb_clk_gen.sv
dv/mic_subsys_assert.sv
dv/tb_mic_subsys.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mic_subsys \
		-f verilog.f -o sim_mic
	@out=$$(./obj_dir/sim_mic 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

/* dv/tb_mic_subsys.sv */
module tb_mic_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_LEN = 64;
    localparam int LAG_MAX   = 8;
    localparam int NUM_RUNS  = 6;
    localparam int DONE_WAIT = 50000;  // a whole capture at this sck rate
    localparam int TAIL_WAIT = 4000;   // last frame plus the sweep
    localparam int FREE      = 99;     // no fixed lag for this channel

    logic           clk;
    logic           rst_n;
    logic           start;
    logic           i2s_sck;
    logic           i2s_ws;
    logic [1:0]     i2s_sd;
    logic           busy;
    logic           done;
    mic_pkg::lag_t  lag_a;
    mic_pkg::lag_t  lag_b;
    mic_pkg::tdoa_t tdoa;

    mic_pkg::sample_t ref_s [FRAME_LEN];
    mic_pkg::sample_t a_s   [FRAME_LEN];
    mic_pkg::sample_t b_s   [FRAME_LEN];
    mic_pkg::sample_t base  [FRAME_LEN + 2 * LAG_MAX];  // shared source for delayed copies
    mic_pkg::lag_t    exp_a_q [$];
    mic_pkg::lag_t    exp_b_q [$];
    mic_pkg::tdoa_t   exp_t_q [$];
    int               checked_count = 0;
    int               done_count = 0;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mic_subsys #(
        .FRAME_LEN (FRAME_LEN),
        .LAG_MAX   (LAG_MAX)
    ) DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .i2s_sck (i2s_sck),
        .i2s_ws  (i2s_ws),
        .i2s_sd  (i2s_sd),
        .busy    (busy),
        .done    (done),
        .lag_a   (lag_a),
        .lag_b   (lag_b),
        .tdoa    (tdoa)
    );

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_now();
        $display(">>> FAIL");
        $fatal(1, "test stopped at the first error");
    endtask

    task automatic check_lag(input string name, input mic_pkg::lag_t got,
                             input mic_pkg::lag_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_tdoa(input string name, input mic_pkg::tdoa_t got,
                              input mic_pkg::tdoa_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic wait_for_done(input int limit, input string what);
        for (int cycles = 0; cycles < limit; cycles++) begin
            @(posedge clk);
            if (done === 1'b1) begin
                return;
            end
        end
        $display("timeout: no done pulse within %0d cycles while %s", limit, what);
        fail_now();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // largest |corr| over all lags, later lag wins a tie, zero outside the frame
    function automatic mic_pkg::lag_t best_lag(input bit use_b);
        longint           corr;
        longint           mag;
        longint           best_mag;
        mic_pkg::lag_t    best;
        int               idx;
        mic_pkg::sample_t y;
        best_mag = 0;
        best     = '0;
        for (int lag = -LAG_MAX; lag <= LAG_MAX; lag++) begin
            corr = 0;
            for (int n = 0; n < FRAME_LEN; n++) begin
                idx = n + lag;
                if (idx >= 0 && idx < FRAME_LEN) begin
                    y    = use_b ? b_s[idx] : a_s[idx];
                    corr = corr + longint'(ref_s[n]) * longint'(y);
                end
            end
            mag = (corr < 0) ? -corr : corr;
            if (mag >= best_mag) begin
                best_mag = mag;
                best     = mic_pkg::lag_t'(lag);
            end
        end
        return best;
    endfunction

    task automatic push_expected(input int want_a, input int want_b);
        mic_pkg::lag_t  la;
        mic_pkg::lag_t  lb;
        mic_pkg::tdoa_t td;
        la = best_lag(1'b0);
        lb = best_lag(1'b1);
        td = mic_pkg::tdoa_t'(int'(lb) - int'(la));
        // sanity of the stimulus against the intended delay
        if (want_a != FREE) check_lag("model lag_a", la, mic_pkg::lag_t'(want_a));
        if (want_b != FREE) check_lag("model lag_b", lb, mic_pkg::lag_t'(want_b));
        exp_a_q.push_back(la);
        exp_b_q.push_back(lb);
        exp_t_q.push_back(td);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic mic_pkg::sample_t rand_sample(input int amp);
        int unsigned r;
        r = $urandom;
        return mic_pkg::sample_t'(int'(r % (2 * amp)) - amp);
    endfunction

    // ch_a[n] = ref[n - da], so its peak sits at lag da
    task automatic build_case(input int da, input int db, input bit rel_a, input bit rel_b,
                              input bit neg_a, input int amp);
        foreach (base[k]) base[k] = rand_sample(amp);
        for (int n = 0; n < FRAME_LEN; n++) begin
            ref_s[n] = base[n + LAG_MAX];
            a_s[n]   = rel_a ? base[n - da + LAG_MAX] : rand_sample(amp);
            b_s[n]   = rel_b ? base[n - db + LAG_MAX] : rand_sample(amp);
            if (!rel_b && db == FREE) b_s[n] = '0;  // every lag ties on a silent channel
            if (neg_a) a_s[n] = -a_s[n];
        end
    endtask

    // one sck period, data set up on the falling half
    task automatic sck_bit(input logic ws_val, input logic [1:0] sd_val);
        @(posedge clk);
        i2s_sck <= 1'b0;
        i2s_ws  <= ws_val;
        i2s_sd  <= sd_val;
        repeat (4) @(posedge clk);
        i2s_sck <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic send_slot(input logic ws_val, input mic_pkg::sample_t w0,
                             input mic_pkg::sample_t w1);
        logic [1:0] bits;
        for (int k = 0; k < 32; k++) begin
            bits = '0;
            if (k >= 1 && k <= 16) bits = {w1[16 - k], w0[16 - k]};  // msb one sck after ws
            sck_bit(ws_val, bits);
        end
    endtask

    task automatic drive_frames();
        sck_bit(1'b1, 2'b00);  // ws high first, so the left slot starts on a ws change
        sck_bit(1'b1, 2'b00);
        for (int f = 0; f < FRAME_LEN; f++) begin
            send_slot(1'b0, 16'h5a5a, a_s[f]);    // line 0 left is unused
            send_slot(1'b1, ref_s[f], b_s[f]);
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        if (busy !== 1'b1) begin
            $display("busy did not rise after an accepted start");
            fail_now();
        end
    endtask

    task automatic run_case(input int da, input int db, input bit rel_a, input bit rel_b,
                            input bit neg_a, input int amp, input int want_a,
                            input int want_b, input bit extra_start);
        build_case(da, db, rel_a, rel_b, neg_a, amp);
        push_expected(want_a, want_b);
        pulse_start();
        fork
            drive_frames();
            begin
                if (extra_start) begin  // lands mid capture
                    repeat (3000) @(posedge clk);
                    start <= 1'b1;
                    @(posedge clk);
                    start <= 1'b0;
                end
            end
        join
        wait_for_done(TAIL_WAIT, "waiting for the sweep to finish");
    endtask

    always @(posedge clk) begin
        if (done === 1'b1) done_count <= done_count + 1;
    end

    initial begin : stimulus
        start   = 1'b0;
        i2s_sck = 1'b0;
        i2s_ws  = 1'b0;
        i2s_sd  = 2'b00;
        void'($urandom(32'h9e90));
        for (int i = 0; i < 20 && rst_n !== 1'b1; i++) @(posedge clk);
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            fail_now();
        end
        run_case(3, -5, 1'b1, 1'b1, 1'b0, 16384, 3, -5, 1'b0);       // known delays
        run_case(0, 0, 1'b1, 1'b0, 1'b1, 16384, 0, FREE, 1'b0);      // inverted copy
        // uncorrelated a and silent b
        run_case(0, FREE, 1'b0, 1'b0, 1'b0, 16384, FREE, LAG_MAX, 1'b0);
        run_case(LAG_MAX, -LAG_MAX, 1'b1, 1'b1, 1'b0, 16384, LAG_MAX, -LAG_MAX, 1'b0);
        run_case(2, -6, 1'b1, 1'b1, 1'b0, 16384, 2, -6, 1'b1);       // start while busy
        // much weaker signal, stale maxima would keep the old lags
        run_case(-4, 1, 1'b1, 1'b1, 1'b0, 256, -4, 1, 1'b0);
        repeat (200) @(posedge clk);
        if (done_count == NUM_RUNS && checked_count == NUM_RUNS && busy === 1'b0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("wrong run count: %0d done pulses, %0d checked, busy %b",
                     done_count, checked_count, busy);
            fail_now();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare
    ////////////////////////////////////////////////////////////////////////////

    initial begin : compare
        mic_pkg::lag_t  ea;
        mic_pkg::lag_t  eb;
        mic_pkg::tdoa_t et;
        for (int r = 0; r < NUM_RUNS; r++) begin
            wait_for_done(DONE_WAIT, "the compare process waited for a result");
            if (exp_a_q.size() == 0) begin
                $display("done pulse arrived with no run pending");
                fail_now();
            end
            ea = exp_a_q.pop_front();
            eb = exp_b_q.pop_front();
            et = exp_t_q.pop_front();
            check_lag("lag_a", lag_a, ea);
            check_lag("lag_b", lag_b, eb);
            check_tdoa("tdoa", tdoa, et);
            if (busy !== 1'b0) begin
                $display("busy still high in the done cycle");
                fail_now();
            end
            checked_count++;
        end
    end

endmodule

/* dv/mic_subsys_assert.sv */
module mic_subsys_assert (
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic busy,
    input logic valid_a,
    input logic valid_b
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////////////////////
    // run end
    ////////////////////////////////////////////////////////////////////////////

    done_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> !done
    ) else $error("done stayed high for more than one cycle");

    // a run has to be in flight before it can finish
    done_after_busy: assert property (
        @(posedge clk) disable iff (!rst_n) done |-> $past(busy)
    ) else $error("done pulsed without busy in the previous cycle");

    ////////////////////////////////////////////////////////////////////////////
    // engine lockstep
    ////////////////////////////////////////////////////////////////////////////

    results_in_step: assert property (
        @(posedge clk) disable iff (!rst_n) valid_a == valid_b
    ) else $error("the two engine results were not valid in the same cycle");

endmodule

bind mic_subsys mic_subsys_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .done    (done),
    .busy    (busy),
    .valid_a (valid_a),
    .valid_b (valid_b)
);

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;  // released on an edge, like the stimulus
    end

endmodule

/* verilog/mic_subsys.sv */
module mic_subsys #(
    parameter int FRAME_LEN = 64,
    parameter int LAG_MAX   = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  logic           i2s_sck,
    input  logic           i2s_ws,
    input  logic [1:0]     i2s_sd,
    output logic           busy,
    output logic           done,
    output mic_pkg::lag_t  lag_a,
    output mic_pkg::lag_t  lag_b,
    output mic_pkg::tdoa_t tdoa
);

    mic_pkg::sample_t       ref_word;      // line 0 right slot
    mic_pkg::sample_t       a_word;        // line 1 left slot
    mic_pkg::sample_t       b_word;        // line 1 right slot
    logic                   frame_strobe;
    mic_pkg::mic_frame_t    frame;
    mic_pkg::mic_stream_t   stream;
    logic                   beat_valid;
    mic_pkg::xcorr_result_t res_a;
    mic_pkg::xcorr_result_t res_b;
    logic                   valid_a;
    logic                   valid_b;       // in step with valid_a

    ////////////////////////////////////////////////////////////////////////////
    // i2s front end
    ////////////////////////////////////////////////////////////////////////////

    // line 0 left slot carries nothing
    i2s_rx u_rx_0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sck          (i2s_sck),
        .ws           (i2s_ws),
        .sd           (i2s_sd[0]),
        .left         (),
        .right        (ref_word),
        .frame_strobe (frame_strobe)
    );

    // shares sck and ws with line 0, so its strobe is not needed
    i2s_rx u_rx_1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sck          (i2s_sck),
        .ws           (i2s_ws),
        .sd           (i2s_sd[1]),
        .left         (a_word),
        .right        (b_word),
        .frame_strobe ()
    );

    assign frame = '{ch_ref: ref_word, ch_a: a_word, ch_b: b_word};

    ////////////////////////////////////////////////////////////////////////////
    // capture, replay and correlation
    ////////////////////////////////////////////////////////////////////////////

    frame_buffer #(
        .FRAME_LEN (FRAME_LEN),
        .LAG_MAX   (LAG_MAX)
    ) u_frame_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .frame        (frame),
        .frame_strobe (frame_strobe),
        .done         (done),
        .stream       (stream),
        .beat_valid   (beat_valid),
        .busy         (busy)
    );

    xcorr_engine u_xcorr_a (
        .clk          (clk),
        .rst_n        (rst_n),
        .x            (stream.ch_ref),
        .y            (stream.ch_a),
        .lag          (stream.lag),
        .first        (stream.first),
        .last         (stream.last),
        .beat_valid   (beat_valid),
        .result       (res_a),
        .result_valid (valid_a)
    );

    xcorr_engine u_xcorr_b (
        .clk          (clk),
        .rst_n        (rst_n),
        .x            (stream.ch_ref),
        .y            (stream.ch_b),
        .lag          (stream.lag),
        .first        (stream.first),
        .last         (stream.last),
        .beat_valid   (beat_valid),
        .result       (res_b),
        .result_valid (valid_b)
    );

    // both engines run in lockstep, one valid serves the pair
    lag_peak #(
        .LAG_MAX (LAG_MAX)
    ) u_lag_peak (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .res_a     (res_a),
        .res_b     (res_b),
        .res_valid (valid_a),
        .lag_a     (lag_a),
        .lag_b     (lag_b),
        .tdoa      (tdoa),
        .done      (done)
    );

endmodule

/* verilog/lag_peak.sv */
module lag_peak #(
    parameter int LAG_MAX = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  mic_pkg::xcorr_result_t res_a,
    input  mic_pkg::xcorr_result_t res_b,
    input  logic                   res_valid,
    output mic_pkg::lag_t          lag_a,
    output mic_pkg::lag_t          lag_b,
    output mic_pkg::tdoa_t         tdoa,
    output logic                   done
);

    localparam int CW = $bits(mic_pkg::corr_t);
    localparam int LW = $bits(mic_pkg::lag_t);

    logic                 armed;     // a run is in flight
    logic [CW-1:0]        mag_a;
    logic [CW-1:0]        mag_b;
    logic [CW-1:0]        max_a;
    logic [CW-1:0]        max_b;
    mic_pkg::lag_t        best_a;
    mic_pkg::lag_t        best_b;
    mic_pkg::lag_t        best_a_nx;
    mic_pkg::lag_t        best_b_nx;
    logic                 take_a;
    logic                 take_b;
    logic                 final_lag;
    mic_pkg::tdoa_t       diff;

    // magnitude of each correlation
    assign mag_a = res_a.corr[CW-1] ? CW'(-res_a.corr) : CW'(res_a.corr);
    assign mag_b = res_b.corr[CW-1] ? CW'(-res_b.corr) : CW'(res_b.corr);

    assign take_a    = (mag_a >= max_a);  // ties go to the later lag
    assign take_b    = (mag_b >= max_b);
    assign best_a_nx = take_a ? res_a.lag : best_a;
    assign best_b_nx = take_b ? res_b.lag : best_b;
    assign final_lag = (res_a.lag == mic_pkg::lag_t'(LAG_MAX));

    assign diff = $signed({best_b_nx[LW-1], best_b_nx}) - $signed({best_a_nx[LW-1], best_a_nx});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed  <= 1'b0;
            max_a  <= '0;
            max_b  <= '0;
            best_a <= '0;
            best_b <= '0;
            lag_a  <= '0;
            lag_b  <= '0;
            tdoa   <= '0;
            done   <= 1'b0;
        end else begin
            done <= res_valid && final_lag;
            if (res_valid) begin
                if (take_a) begin
                    max_a  <= mag_a;
                    best_a <= res_a.lag;
                end
                if (take_b) begin
                    max_b  <= mag_b;
                    best_b <= res_b.lag;
                end
                if (final_lag) begin  // publish, held until next done
                    lag_a <= best_a_nx;
                    lag_b <= best_b_nx;
                    tdoa  <= diff;
                end
            end
            // same acceptance rule as frame_buffer, so a late start is ignored
            if (start && !armed) begin
                armed  <= 1'b1;
                max_a  <= '0;
                max_b  <= '0;
                best_a <= '0;
                best_b <= '0;
            end else if (done) begin
                armed <= 1'b0;
            end
        end
    end

endmodule

/* verilog/xcorr_engine.sv */
module xcorr_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mic_pkg::sample_t       x,
    input  mic_pkg::sample_t       y,
    input  mic_pkg::lag_t          lag,
    input  logic                   first,
    input  logic                   last,
    input  logic                   beat_valid,
    output mic_pkg::xcorr_result_t result,
    output logic                   result_valid
);

    mic_pkg::corr_t prod;
    mic_pkg::corr_t acc;
    mic_pkg::corr_t sum;

    ////////////////////////////////////////////////////////////////////////////
    // multiply-accumulate
    ////////////////////////////////////////////////////////////////////////////

    // operands are sign extended to the accumulator width before the multiply
    assign prod = x * y;

    // first beat of a lag restarts the sum
    assign sum = first ? prod : acc + prod;

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            acc <= sum;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // result, one per lag
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (beat_valid && last) begin
            result.corr <= sum;  // includes the last product
            result.lag  <= lag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= beat_valid & last;
        end
    end

endmodule

/* verilog/frame_buffer.sv */
module frame_buffer #(
    parameter int FRAME_LEN = 64,
    parameter int LAG_MAX   = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  mic_pkg::mic_frame_t  frame,
    input  logic                 frame_strobe,
    input  logic                 done,
    output mic_pkg::mic_stream_t stream,
    output logic                 beat_valid,
    output logic                 busy
);

    localparam int AW = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;
    localparam int LW = $bits(mic_pkg::lag_t);
    localparam int IW = ((AW > LW) ? AW : LW) + 2;  // n + lag, signed, no overflow

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_SWEEP
    } state_t;

    state_t               state;
    logic [AW-1:0]        wr_addr;
    logic [AW-1:0]        n;
    mic_pkg::lag_t        lag;
    logic                 replay_on;   // beats still to go in this sweep
    logic                 n_last;
    logic                 capture_end;
    logic signed [IW-1:0] lag_ext;
    logic signed [IW-1:0] idx;
    logic                 idx_ok;
    logic [AW-1:0]        rd_addr;

    mic_pkg::sample_t mem_ref [FRAME_LEN];
    mic_pkg::sample_t mem_a   [FRAME_LEN];
    mic_pkg::sample_t mem_b   [FRAME_LEN];

    assign capture_end = frame_strobe && (wr_addr == AW'(FRAME_LEN - 1));
    assign n_last      = (n == AW'(FRAME_LEN - 1));

    // shifted read index for ch_a / ch_b
    assign lag_ext = {{(IW - LW){lag[LW-1]}}, lag};
    assign idx     = $signed({{(IW - AW){1'b0}}, n}) + lag_ext;
    assign idx_ok  = (idx >= 0) && (idx < FRAME_LEN);
    assign rd_addr = idx[AW-1:0];

    assign busy = (state != ST_IDLE) && !done;  // drops with done

    ////////////////////////////////////////////////////////////////////////////
    // controller
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            wr_addr   <= '0;
            n         <= '0;
            lag       <= '0;
            replay_on <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_CAPTURE;
                        wr_addr <= '0;
                    end
                end
                ST_CAPTURE: begin
                    if (frame_strobe) begin
                        wr_addr <= wr_addr + 1'b1;
                    end
                    if (capture_end) begin
                        state     <= ST_SWEEP;
                        n         <= '0;
                        lag       <= mic_pkg::lag_t'(-LAG_MAX);
                        replay_on <= 1'b1;
                    end
                end
                ST_SWEEP: begin
                    if (replay_on) begin
                        n <= n_last ? '0 : n + 1'b1;
                        if (n_last) begin
                            if (lag == mic_pkg::lag_t'(LAG_MAX)) begin
                                replay_on <= 1'b0;
                            end else begin
                                lag <= lag + 1'b1;
                            end
                        end
                    end
                    if (done) begin
                        state <= ST_IDLE;  // end of run is lag_peak's call
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sample memories and replay beat
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if ((state == ST_CAPTURE) && frame_strobe) begin
            mem_ref[wr_addr] <= frame.ch_ref;
            mem_a[wr_addr]   <= frame.ch_a;
            mem_b[wr_addr]   <= frame.ch_b;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= (state == ST_SWEEP) && replay_on;
        end
    end

    always_ff @(posedge clk) begin
        stream.ch_ref <= mem_ref[n];
        stream.ch_a   <= idx_ok ? mem_a[rd_addr] : '0;  // zero pad outside frame
        stream.ch_b   <= idx_ok ? mem_b[rd_addr] : '0;
        stream.lag    <= lag;
        stream.first  <= (n == '0);
        stream.last   <= n_last;
    end

endmodule

/* verilog/i2s_rx.sv */
module i2s_rx (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sck,
    input  logic             ws,
    input  logic             sd,
    output mic_pkg::sample_t left,
    output mic_pkg::sample_t right,
    output logic             frame_strobe
);

    logic [1:0]  sck_sync;
    logic [1:0]  ws_sync;
    logic [1:0]  sd_sync;
    logic        sck_last;
    logic        sck_rise;
    logic        ws_last;    // ws at the previous sck rise
    logic        ws_same;
    logic [4:0]  bit_cnt;    // sck rises since the ws change
    logic [15:0] shift;
    logic        word_done;

    // double-flop sync, then edge detect on the synced sck
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck_sync <= '0;
            ws_sync  <= '0;
            sd_sync  <= '0;
            sck_last <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[0], sck};
            ws_sync  <= {ws_sync[0], ws};
            sd_sync  <= {sd_sync[0], sd};
            sck_last <= sck_sync[1];
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_last;
    assign ws_same   = (ws_sync[1] == ws_last);
    // msb arrives one sck after ws flips, so bit 15 lands at count 15
    assign word_done = sck_rise && ws_same && (bit_cnt == 5'd15);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ws_last      <= 1'b0;
            bit_cnt      <= '0;
            frame_strobe <= 1'b0;
        end else begin
            frame_strobe <= word_done & ws_last;  // right word finished
            if (sck_rise) begin
                ws_last <= ws_sync[1];
                if (!ws_same) begin
                    bit_cnt <= '0;
                end else if (bit_cnt != 5'd31) begin
                    bit_cnt <= bit_cnt + 5'd1;  // hold at end of long slots
                end
            end
        end
    end

    // datapath, top 16 bits of each 32 bit slot
    always_ff @(posedge clk) begin
        if (sck_rise && ws_same && (bit_cnt < 5'd16)) begin
            shift <= {shift[14:0], sd_sync[1]};
        end
        if (word_done) begin
            if (ws_last) begin
                right <= {shift[14:0], sd_sync[1]};
            end else begin
                left <= {shift[14:0], sd_sync[1]};  // ws low = left
            end
        end
    end

endmodule

/* verilog/mic_pkg.sv */
package mic_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [15:0] sample_t;  // one mic sample, msb first on i2s
    typedef logic signed [5:0]  lag_t;     // covers +/-31
    typedef logic signed [6:0]  tdoa_t;    // lag_b - lag_a
    typedef logic signed [39:0] corr_t;    // headroom for long frames

    ////////////////////////////////////////////////////////////////////////////
    // structured types
    ////////////////////////////////////////////////////////////////////////////

    // one captured frame, all three mics at the same instant
    typedef struct packed {
        sample_t ch_ref;  // line 0 right slot
        sample_t ch_a;    // line 1 left slot
        sample_t ch_b;    // line 1 right slot
    } mic_frame_t;

    // one replay beat
    // ch_a and ch_b are taken at n + lag, zero outside the frame
    typedef struct packed {
        sample_t ch_ref;
        sample_t ch_a;
        sample_t ch_b;
        lag_t    lag;
        logic    first;   // n == 0
        logic    last;    // n == FRAME_LEN - 1
    } mic_stream_t;

    // correlation of one pair at one lag
    typedef struct packed {
        lag_t  lag;
        corr_t corr;
    } xcorr_result_t;

endpackage
